// File: hyper_cmd_decode.sv
`timescale 1ns/1ps
// Accepts one request strobe while the bus is idle and builds its CA word
// A strobe seen while busy_i is high is dropped without notice

`include "hyper_ctrl_macros.svh"

module hyper_cmd_decode (
    input  logic                 sys_clk,
    input  logic                 reset_i,
    input  logic                 req_valid_i,
    input  hyper_ctrl_pkg::req_t req_i,
    input  logic                 busy_i,
    output logic                 cmd_valid_o,
    output hyper_ctrl_pkg::cmd_t cmd_o
);

    hyper_ctrl_pkg::ca_word_u ca;
    logic                     accept;

    assign accept = req_valid_i & ~busy_i;

    // Memory space, linear burst, reserved bits zero
    always_comb begin
        ca.fields = '{
            rw_n:         ~req_i.write,
            addr_space:   1'b0,
            burst_linear: 1'b1,
            addr_hi:      req_i.addr[`HYPER_ADDR_W-1:3],
            reserved:     13'h0,
            addr_lo:      req_i.addr[2:0]
        };
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= accept;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            cmd_o.ca    <= ca;
            cmd_o.write <= req_i.write;
            cmd_o.wdata <= req_i.wdata;
        end
    end

endmodule

// File: hyper_ctrl.f
+incdir+.
hyper_ctrl_pkg.sv
hyper_cmd_decode.sv
hyper_phy_execute.sv
hyper_read_result.sv
hyper_ctrl_top.sv
hyper_ram_model.sv
hyper_ctrl_props.sv
tb_hyper_ctrl.sv

// File: hyper_ctrl_macros.svh
// Build constants for the single-chip HyperBus controller
// Latency is fixed. RWDS-signalled doubling is not supported

`ifndef HYPER_CTRL_MACROS_SVH
`define HYPER_CTRL_MACROS_SVH

// Word address width of a request
`define HYPER_ADDR_W 32

// One 16-bit word per transaction
`define HYPER_DATA_W 16

// Command/address bytes sent before latency
`define HYPER_CA_BYTES 6

// sys_clk cycles from last CA byte to first data byte
`define HYPER_LATENCY 6

`endif

// File: hyper_ctrl_pkg.sv
// Types shared by the controller stages
// The CA layout assumes a 32-bit word address and memory space only

`include "hyper_ctrl_macros.svh"

package hyper_ctrl_pkg;

    typedef struct packed {
        logic                     write;
        logic [`HYPER_ADDR_W-1:0] addr;
        logic [`HYPER_DATA_W-1:0] wdata;
    } req_t;

    typedef struct packed {
        logic                     write;
        logic [`HYPER_DATA_W-1:0] rdata;
        logic                     error;
    } rsp_t;

    // HyperBus CA word as transmitted
    typedef struct packed {
        logic                     rw_n;
        logic                     addr_space;
        logic                     burst_linear;
        logic [`HYPER_ADDR_W-4:0] addr_hi;
        logic [12:0]              reserved;
        logic [2:0]               addr_lo;
    } ca_fields_t;

    // Byte 0 is the first byte on DQ
    typedef union packed {
        ca_fields_t                          fields;
        logic [0:`HYPER_CA_BYTES-1][7:0]     bytes;
    } ca_word_u;

    typedef struct packed {
        ca_word_u                 ca;
        logic                     write;
        logic [`HYPER_DATA_W-1:0] wdata;
    } cmd_t;

    typedef struct packed {
        logic [`HYPER_DATA_W-1:0] data;
        logic                     rwds_seen;
    } rd_capture_t;

endpackage

// File: hyper_ctrl_props.sv
`timescale 1ns/1ps
// Pin-level HyperBus properties bound into hyper_ctrl_top
// Assumes one word per transaction, so CS stays low for 14 cycles

module hyper_ctrl_props (
    input logic sys_clk,
    input logic reset_i,
    input logic cs_n_i,
    input logic ck_i,
    input logic dq_oe_i,
    input logic rwds_oe_i,
    input logic busy_i,
    input logic rsp_valid_i
);

    logic reset_q = 1'b0;

    always @(posedge sys_clk) begin
        reset_q <= reset_i;
    end

    oe_inside_cs: assert property (@(posedge sys_clk) disable iff (reset_i)
        cs_n_i |-> !dq_oe_i && !rwds_oe_i)
        else $error("DQ or RWDS output enable high while CS is deasserted");

    // 6 CA, 6 latency and 2 data cycles
    cs_low_window: assert property (@(posedge sys_clk) disable iff (reset_i)
        $fell(cs_n_i) |-> ##14 $rose(cs_n_i))
        else $error("CS did not return high 14 cycles after falling");

    cs_no_early_rise: assert property (@(posedge sys_clk) disable iff (reset_i)
        $rose(cs_n_i) |-> $past(cs_n_i, 15) && !$past(cs_n_i, 14))
        else $error("CS rose without a full 14-cycle low window");

    // CK runs on every cycle of the CS-low window after the first
    ck_toggles: assert property (@(posedge sys_clk) disable iff (reset_i)
        !cs_n_i && !$past(cs_n_i) |-> ck_i != $past(ck_i))
        else $error("CK did not toggle while CS was low");

    quiet_in_reset: assert property (@(posedge sys_clk)
        reset_i && reset_q |-> cs_n_i && !ck_i && !dq_oe_i && !rwds_oe_i
                               && !busy_i && !rsp_valid_i)
        else $error("Control output active during reset");

endmodule

bind hyper_ctrl_top hyper_ctrl_props props_i (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .cs_n_i      (cs_n_o),
    .ck_i        (ck_o),
    .dq_oe_i     (dq_oe_o),
    .rwds_oe_i   (rwds_oe_o),
    .busy_i      (busy_o),
    .rsp_valid_i (rsp_valid_o)
);

// File: hyper_ctrl_stimulus.txt
# op addr wdata exp_rdata exp_err drop_rwds, all hex
# op: 0 read, 1 write, 2 read with a rejected write strobe of wdata while busy
1 00000010 1234 0000 0 0
0 00000010 0000 1234 0 0
0 00000021 0000 5a7b 0 0
1 000000ff beef 0000 0 0
0 000000ff 0000 beef 0 0
0 00000080 0000 5ada 0 0
2 00000033 dead 5a69 0 0
0 00000033 0000 5a69 0 0
0 00000044 0000 5a1e 1 1
0 00000044 0000 5a1e 0 0
1 12340077 a5c3 0000 0 0
0 12340077 0000 a5c3 0 0
1 00000005 0001 0000 0 0
1 00000005 fffe 0000 0 0
0 00000005 0000 fffe 0 0

// File: hyper_ctrl_top.sv
`timescale 1ns/1ps
// Single-chip HyperBus controller with split DQ and RWDS pins
// Pad tristates live outside. Response follows an accepted strobe by 17 cycles

module hyper_ctrl_top (
    input  logic                 sys_clk,
    input  logic                 reset_i,
    input  logic                 req_valid_i,
    input  hyper_ctrl_pkg::req_t req_i,
    output logic                 busy_o,
    output logic                 rsp_valid_o,
    output hyper_ctrl_pkg::rsp_t rsp_o,
    output logic                 cs_n_o,
    output logic                 ck_o,
    output logic [7:0]           dq_o,
    output logic                 dq_oe_o,
    input  logic [7:0]           dq_i,
    output logic                 rwds_o,
    output logic                 rwds_oe_o,
    input  logic                 rwds_i
);

    logic                        cmd_valid;
    hyper_ctrl_pkg::cmd_t        cmd;
    logic                        cap_valid;
    hyper_ctrl_pkg::rd_capture_t cap;
    logic                        wr_done;

    hyper_cmd_decode u_decode (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_i      (busy_o),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd)
    );

    hyper_phy_execute u_execute (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .busy_o      (busy_o),
        .cs_n_o      (cs_n_o),
        .ck_o        (ck_o),
        .dq_o        (dq_o),
        .dq_oe_o     (dq_oe_o),
        .dq_i        (dq_i),
        .rwds_o      (rwds_o),
        .rwds_oe_o   (rwds_oe_o),
        .rwds_i      (rwds_i),
        .cap_valid_o (cap_valid),
        .cap_o       (cap),
        .wr_done_o   (wr_done)
    );

    hyper_read_result u_result (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .cap_valid_i (cap_valid),
        .cap_i       (cap),
        .wr_done_i   (wr_done),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

// File: hyper_phy_execute.sv
`timescale 1ns/1ps
// Drives the HyperBus pins for one word per transaction
// Each DQ byte takes one sys_clk cycle and CK toggles every cycle while CS is low
// RWDS is only checked for toggling on reads and is held low on writes

`include "hyper_ctrl_macros.svh"

module hyper_phy_execute (
    input  logic                        sys_clk,
    input  logic                        reset_i,
    input  logic                        cmd_valid_i,
    input  hyper_ctrl_pkg::cmd_t        cmd_i,
    output logic                        busy_o,
    output logic                        cs_n_o,
    output logic                        ck_o,
    output logic [7:0]                  dq_o,
    output logic                        dq_oe_o,
    input  logic [7:0]                  dq_i,
    output logic                        rwds_o,
    output logic                        rwds_oe_o,
    input  logic                        rwds_i,
    output logic                        cap_valid_o,
    output hyper_ctrl_pkg::rd_capture_t cap_o,
    output logic                        wr_done_o
);

    localparam int CNT_MAX = (`HYPER_CA_BYTES > `HYPER_LATENCY) ?
                             `HYPER_CA_BYTES : `HYPER_LATENCY;
    localparam int CNT_W = $clog2(CNT_MAX);
    localparam logic [CNT_W-1:0] CA_LAST   = CNT_W'(`HYPER_CA_BYTES - 1);
    localparam logic [CNT_W-1:0] LAT_LAST  = CNT_W'(`HYPER_LATENCY - 1);
    localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(`HYPER_DATA_W / 8 - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CA,
        S_LAT,
        S_DATA,
        S_FIN
    } state_t;

    state_t                   state;
    logic [CNT_W-1:0]         cnt;
    hyper_ctrl_pkg::ca_word_u ca_sr;
    logic                     is_write;
    logic [`HYPER_DATA_W-1:0] wdata_sr;
    logic [`HYPER_DATA_W-1:0] rd_data;
    logic                     rwds_q;
    logic                     rwds_seen;
    logic                     rwds_changed;

    assign rwds_changed = rwds_i ^ rwds_q;

    assign busy_o      = cmd_valid_i | (state != S_IDLE);
    assign rwds_o      = 1'b0;
    assign cap_valid_o = (state == S_FIN) & ~is_write;
    assign wr_done_o   = (state == S_FIN) & is_write;
    assign cap_o.data      = rd_data;
    assign cap_o.rwds_seen = rwds_seen;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state     <= S_IDLE;
            cnt       <= '0;
            cs_n_o    <= 1'b1;
            ck_o      <= 1'b0;
            dq_oe_o   <= 1'b0;
            rwds_oe_o <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    cnt  <= '0;
                    ck_o <= 1'b0;
                    if (cmd_valid_i) begin
                        state   <= S_CA;
                        cs_n_o  <= 1'b0;
                        dq_oe_o <= 1'b1;
                    end
                end
                S_CA: begin
                    ck_o <= ~ck_o;
                    if (cnt == CA_LAST) begin
                        state   <= S_LAT;
                        cnt     <= '0;
                        dq_oe_o <= 1'b0;
                    end
                end
                S_LAT: begin
                    ck_o <= ~ck_o;
                    if (cnt == LAT_LAST) begin
                        state     <= S_DATA;
                        cnt       <= '0;
                        dq_oe_o   <= is_write;
                        rwds_oe_o <= is_write;
                    end
                end
                S_DATA: begin
                    ck_o <= ~ck_o;
                    if (cnt == DATA_LAST) begin
                        state     <= S_FIN;
                        cs_n_o    <= 1'b1;
                        ck_o      <= 1'b0;
                        dq_oe_o   <= 1'b0;
                        rwds_oe_o <= 1'b0;
                    end
                end
                default: begin
                    state <= S_IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // Shift registers for CA, write data and read capture
    always_ff @(posedge sys_clk) begin
        rwds_q <= rwds_i;
        case (state)
            S_IDLE: begin
                if (cmd_valid_i) begin
                    ca_sr    <= cmd_i.ca;
                    dq_o     <= cmd_i.ca.bytes[0];
                    is_write <= cmd_i.write;
                    wdata_sr <= cmd_i.wdata;
                end
            end
            S_CA: begin
                ca_sr.bytes <= {ca_sr.bytes[1:`HYPER_CA_BYTES-1], 8'h00};
                dq_o        <= ca_sr.bytes[1];
            end
            S_LAT: begin
                // High byte goes first
                dq_o <= wdata_sr[`HYPER_DATA_W-1 -: 8];
            end
            S_DATA: begin
                wdata_sr <= {wdata_sr[`HYPER_DATA_W-9:0], 8'h00};
                dq_o     <= wdata_sr[`HYPER_DATA_W-9 -: 8];
                rd_data  <= {rd_data[`HYPER_DATA_W-9:0], dq_i};
                if (cnt == '0) begin
                    rwds_seen <= rwds_changed;
                end else begin
                    rwds_seen <= rwds_seen & rwds_changed;
                end
            end
            default: begin
                dq_o <= 8'h00;
            end
        endcase
    end

endmodule

// File: hyper_ram_model.sv
`timescale 1ns/1ps
// HyperRAM stand-in on split DQ and RWDS pins, 256 words selected by the low address bits
// Fixed latency only. drop_rwds_i keeps RWDS still during read data

`include "hyper_ctrl_macros.svh"

module hyper_ram_model (
    input  logic       sys_clk,
    input  logic       reset_i,
    input  logic       cs_n_i,
    input  logic [7:0] dq_i,
    input  logic       dq_oe_i,
    input  logic       drop_rwds_i,
    output logic [7:0] dq_o,
    output logic       rwds_o
);

    localparam int DATA_START = `HYPER_CA_BYTES + `HYPER_LATENCY;

    logic [15:0] mem [0:255];
    logic [47:0] ca_sr;
    logic [7:0]  wr_hi;
    logic [7:0]  dq_q = 8'h00;
    logic        rwds_q = 1'b0;
    int          cnt = 0;
    logic        rd;
    logic [7:0]  idx;

    // rw_n on top, addr[7:3] from the upper field, addr[2:0] at the bottom
    assign rd     = ca_sr[47];
    assign idx    = {ca_sr[20:16], ca_sr[2:0]};
    assign dq_o   = dq_q;
    assign rwds_o = rwds_q;

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] = 16'(a) ^ 16'h5a5a;
        end
    end

    always @(posedge sys_clk) begin
        if (reset_i || cs_n_i) begin
            cnt <= 0;
        end else begin
            cnt <= cnt + 1;
        end
        if (reset_i) begin
            dq_q   <= 8'h00;
            rwds_q <= 1'b0;
        end else if (!cs_n_i) begin
            if (cnt < `HYPER_CA_BYTES) begin
                ca_sr <= {ca_sr[39:0], dq_i};
            end else if (cnt == DATA_START - 1 && rd) begin
                dq_q   <= mem[idx][15:8];
                rwds_q <= rwds_q ^ ~drop_rwds_i;
            end else if (cnt == DATA_START && rd) begin
                dq_q   <= mem[idx][7:0];
                rwds_q <= rwds_q ^ ~drop_rwds_i;
            end else if (cnt == DATA_START && dq_oe_i) begin
                wr_hi <= dq_i;
            end else if (cnt == DATA_START + 1 && !rd && dq_oe_i) begin
                mem[idx] <= {wr_hi, dq_i};
            end
        end
    end

endmodule

// File: hyper_read_result.sv
`timescale 1ns/1ps
// Turns a finished bus transaction into a one-cycle response
// A read without RWDS toggling on every byte is flagged as an error

module hyper_read_result (
    input  logic                        sys_clk,
    input  logic                        reset_i,
    input  logic                        cap_valid_i,
    input  hyper_ctrl_pkg::rd_capture_t cap_i,
    input  logic                        wr_done_i,
    output logic                        rsp_valid_o,
    output hyper_ctrl_pkg::rsp_t        rsp_o
);

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= cap_valid_i | wr_done_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (cap_valid_i) begin
            rsp_o.write <= 1'b0;
            rsp_o.rdata <= cap_i.data;
            rsp_o.error <= ~cap_i.rwds_seen;
        end else if (wr_done_i) begin
            // Writes carry no data back
            rsp_o.write <= 1'b1;
            rsp_o.rdata <= '0;
            rsp_o.error <= 1'b0;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the HyperBus controller testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f hyper_ctrl.f --top-module tb_hyper_ctrl \
    && ./obj_dir/Vtb_hyper_ctrl > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q -e "CHECKS FAILED" -e "%Error" sim.log 2>/dev/null \
    && { echo "Simulation FAILED"; exit 1; } \
    || grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
    || { echo "Simulation FAILED: no result in sim.log"; exit 1; }
echo "Simulation PASSED"

// File: tb_hyper_ctrl.sv
`timescale 1ns/1ps
// Runs every line of hyper_ctrl_stimulus.txt through the controller and checks the response
// Expects the response exactly 17 cycles after each accepted strobe

module tb_hyper_ctrl;

    typedef struct packed {
        logic [3:0]  op;
        logic [31:0] addr;
        logic [15:0] wdata;
        logic [15:0] rdata;
        logic        err;
        logic        drop;
    } line_t;

    logic                 sys_clk;
    logic                 reset_i;
    logic                 req_valid_i;
    hyper_ctrl_pkg::req_t req_i;
    logic                 busy_o;
    logic                 rsp_valid_o;
    hyper_ctrl_pkg::rsp_t rsp_o;
    logic                 cs_n_o;
    logic                 ck_o;
    logic [7:0]           dq_o;
    logic                 dq_oe_o;
    logic [7:0]           dq_i;
    logic                 rwds_o;
    logic                 rwds_oe_o;
    logic                 rwds_i;
    logic                 drop_rwds;
    line_t                lines[$];
    logic [31:0]          seed;
    int                   cycle_count = 0;
    int                   cycle_limit = 1000;

    hyper_ctrl_top dut_i (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .cs_n_o      (cs_n_o),
        .ck_o        (ck_o),
        .dq_o        (dq_o),
        .dq_oe_o     (dq_oe_o),
        .dq_i        (dq_i),
        .rwds_o      (rwds_o),
        .rwds_oe_o   (rwds_oe_o),
        .rwds_i      (rwds_i)
    );

    hyper_ram_model ram_i (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .cs_n_i      (cs_n_o),
        .dq_i        (dq_o),
        .dq_oe_i     (dq_oe_o),
        .drop_rwds_i (drop_rwds),
        .dq_o        (dq_i),
        .rwds_o      (rwds_i)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        string       text;
        logic [31:0] f_op, f_addr, f_wdata, f_rdata, f_err, f_drop;
        fd = $fopen("hyper_ctrl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file hyper_ctrl_stimulus.txt");
            $display("CHECKS FAILED");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            if ($fgets(text, fd) != 0 && $sscanf(text, "%h %h %h %h %h %h", f_op, f_addr,
                                                 f_wdata, f_rdata, f_err, f_drop) == 6) begin
                lines.push_back({f_op[3:0], f_addr, f_wdata[15:0], f_rdata[15:0],
                                 f_err[0], f_drop[0]});
            end
        end
        $fclose(fd);
    endtask

    // Op 2 is a read with a write strobe thrown in while busy
    task automatic run_line(input line_t t);
        logic [1:0]  gap;
        logic [47:0] ca_word;
        // R/W# first, then space, burst, upper address, reserved bits and lower address
        ca_word     = {t.op != 4'd1, 1'b0, 1'b1, t.addr[31:3], 13'h0, t.addr[2:0]};
        req_i       = {t.op == 4'd1, t.addr, t.wdata};
        drop_rwds   = t.drop;
        req_valid_i = 1'b1;
        for (int i = 1; i <= 18; i++) begin
            @(negedge sys_clk);
            req_valid_i = (t.op == 4'd2) && (i == 5);
            req_i.write = (t.op != 4'd0);
            check_value("rsp_valid_o", 32'(rsp_valid_o), 32'(i == 17));
            check_value("busy_o", 32'(busy_o), 32'(i < 17));
            if (i == 14 || i == 15) begin
                check_value("rwds_oe_o", 32'(rwds_oe_o), 32'(t.op == 4'd1));
                // RWDS low masks no byte of a write
                if (t.op == 4'd1) begin
                    check_value("rwds_o", 32'(rwds_o), 32'd0);
                end
            end
            if (i == 17) begin
                check_value("ca_word", ram_i.ca_sr, ca_word);
                check_value("rsp_o.write", 32'(rsp_o.write), 32'(t.op == 4'd1));
                check_value("rsp_o.rdata", 32'(rsp_o.rdata), 32'(t.rdata));
                check_value("rsp_o.error", 32'(rsp_o.error), 32'(t.err));
            end
        end
        drop_rwds = 1'b0;
        seed      = next_rand(seed);
        gap       = seed[17:16];
        repeat (gap) begin
            @(negedge sys_clk);
            check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        drop_rwds   = 1'b0;
        seed        = 32'h4cab;
        load_stimulus();
        cycle_limit = lines.size() * 24 + 50;
        repeat (8) @(posedge sys_clk);
        @(negedge sys_clk);
        reset_i = 1'b0;
        foreach (lines[k]) begin
            run_line(lines[k]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
